// File: ex_pkg.sv
package ex_pkg;

	// ==============================
	// widths
	// ==============================
	localparam int XLEN    = 32;
	localparam int SHAMT_W = 5;
	localparam int HALF_W  = XLEN / 2;       // split point of the multiplier operand
	localparam int PP_W    = XLEN + HALF_W + 2; // 33 x 17 signed partial product

	typedef logic [XLEN-1:0]   xlen_t;
	typedef logic [2*XLEN-1:0] dword_t;

	localparam xlen_t PC_ALIGN_MASK = 32'hffff_fffe; // jalr target has bit 0 cleared

	// ==============================
	// opcode encodings
	// ==============================
	// bit positions in the one-hot alu opcode
	typedef enum int unsigned {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_LUI,
		OP_LT,
		OP_LTU,
		OP_EQ,
		OP_NE,
		OP_GE,
		OP_GEU
	} op_idx_e;

	localparam int N_OPS = 15;

	typedef logic [N_OPS-1:0] op_type_t;

	typedef enum logic [2:0] {
		MUL_NONE   = 3'd0,
		MUL_MUL    = 3'd1,
		MUL_MULH   = 3'd2,
		MUL_MULHSU = 3'd3,
		MUL_MULHU  = 3'd4
	} mul_type_e;

	// ==============================
	// stage payloads
	// ==============================
	typedef struct packed {
		xlen_t     alu_res;
		dword_t    part0;
		dword_t    part1;
		mul_type_e mul_type;
		logic      branch_taken;
		xlen_t     target;
	} ex1_t;

	typedef struct packed {
		xlen_t result;
		logic  branch_taken;
		xlen_t target;
	} res_t;

endpackage

// File: int_alu.sv
`timescale 1ns/1ns

module int_alu
	import ex_pkg::*;
(
	input  op_type_t op_type,
	input  xlen_t    op0,
	input  xlen_t    op1,
	input  xlen_t    pc,
	input  xlen_t    imm,
	input  xlen_t    rs1_data,
	input  logic     is_branch,
	input  logic     is_jalr,
	output xlen_t    alu_res,
	output logic     branch_taken,
	output xlen_t    branch_target
);

	function automatic xlen_t bit_rev(input xlen_t v);
		xlen_t r;
		for (int i = 0; i < XLEN; i++) begin
			r[i] = v[XLEN-1-i];
		end
		return r;
	endfunction

	logic                is_add;
	logic                is_cmp;
	logic                is_sub;
	xlen_t               add_a;
	xlen_t               add_b;
	xlen_t               sum;
	logic                lt;
	logic                ltu;
	logic                eq;
	logic                cmp_hit;
	logic [SHAMT_W-1:0]  shamt;
	xlen_t               shift_in;
	xlen_t               shr;
	xlen_t               sra_mask;

	// ==============================
	// shared adder
	// ==============================
	assign is_add = op_type[OP_ADD];
	assign is_cmp = op_type[OP_LT] | op_type[OP_LTU] | op_type[OP_EQ] | op_type[OP_NE]
		| op_type[OP_GE] | op_type[OP_GEU];
	assign is_sub = op_type[OP_SUB] | is_cmp;

	assign add_a = (is_add || is_sub) ? op0 : '0;
	assign add_b = is_add ? op1 : (is_sub ? ~op1 : '0);
	assign sum   = add_a + add_b + xlen_t'(is_sub); // two's complement subtract

	// signs decide when they differ, else the difference sign does
	assign lt  = (op0[XLEN-1] != op1[XLEN-1]) ? op0[XLEN-1] : sum[XLEN-1];
	assign ltu = (op0[XLEN-1] != op1[XLEN-1]) ? op1[XLEN-1] : sum[XLEN-1];
	assign eq  = (sum == '0);

	assign cmp_hit = (op_type[OP_LT] & lt) | (op_type[OP_LTU] & ltu)
		| (op_type[OP_EQ] & eq) | (op_type[OP_NE] & ~eq)
		| (op_type[OP_GE] & ~lt) | (op_type[OP_GEU] & ~ltu);

	// ==============================
	// shifter
	// ==============================
	assign shamt    = op1[SHAMT_W-1:0];
	assign shift_in = op_type[OP_SLL] ? bit_rev(op0) : op0; // sll runs reversed
	assign shr      = shift_in >> shamt;
	assign sra_mask = (op_type[OP_SRA] && op0[XLEN-1]) ? ~({XLEN{1'b1}} >> shamt) : '0;

	// one-hot select, every unselected term is zero
	assign alu_res = ({XLEN{is_add | op_type[OP_SUB]}} & sum)
		| ({XLEN{op_type[OP_AND]}} & (op0 & op1))
		| ({XLEN{op_type[OP_OR]}} & (op0 | op1))
		| ({XLEN{op_type[OP_XOR]}} & (op0 ^ op1))
		| ({XLEN{op_type[OP_SLL]}} & bit_rev(shr))
		| ({XLEN{op_type[OP_SRL]}} & shr)
		| ({XLEN{op_type[OP_SRA]}} & (shr | sra_mask))
		| ({XLEN{op_type[OP_LUI]}} & op1)
		| {{(XLEN-1){1'b0}}, cmp_hit};

	// ==============================
	// branch resolution
	// ==============================
	assign branch_taken = is_jalr | (is_branch & cmp_hit);

	always_comb begin
		if (is_branch) begin
			branch_target = pc + imm;
		end else if (is_jalr) begin
			branch_target = (rs1_data + imm) & PC_ALIGN_MASK;
		end else begin
			branch_target = '0;
		end
	end

	a_op_onehot: assert final ($onehot0(op_type))
		else $error("op_type is not one-hot: %h", op_type);

endmodule

// File: mul_partial.sv
`timescale 1ns/1ns

module mul_partial
	import ex_pkg::*;
(
	input  mul_type_e mul_type,
	input  xlen_t     op0,
	input  xlen_t     op1,
	output dword_t    part0,
	output dword_t    part1
);

	logic                    a_sgn;
	logic                    b_sgn;
	logic signed [XLEN:0]    a_ext;
	logic signed [XLEN:0]    b_ext;
	logic signed [HALF_W:0]  b_lo;
	logic signed [HALF_W:0]  b_hi;
	logic signed [PP_W-1:0]  pp_lo;
	logic signed [PP_W-1:0]  pp_hi;
	dword_t                  hi_ext;

	assign a_sgn = (mul_type == MUL_MULH) || (mul_type == MUL_MULHSU);
	assign b_sgn = (mul_type == MUL_MULH);

	// 33 bit operands cover both signed and unsigned kinds
	assign a_ext = {a_sgn & op0[XLEN-1], op0};
	assign b_ext = {b_sgn & op1[XLEN-1], op1};

	assign b_lo = {1'b0, b_ext[HALF_W-1:0]}; // low half is always positive
	assign b_hi = b_ext[XLEN:HALF_W];

	assign pp_lo = a_ext * b_lo;
	assign pp_hi = a_ext * b_hi;

	assign hi_ext = {{(2*XLEN-PP_W){pp_hi[PP_W-1]}}, pp_hi};

	assign part0 = (mul_type == MUL_NONE) ? '0 : {{(2*XLEN-PP_W){pp_lo[PP_W-1]}}, pp_lo};
	assign part1 = (mul_type == MUL_NONE) ? '0 : (hi_ext << HALF_W);

endmodule

// File: pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  logic     out_ready,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data
);

	logic load;

	// free slot, or the current entry leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_data <= in_data;
		end
	end

	// a stalled entry must not move under the consumer
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	) else $error("stalled payload changed");

endmodule

// File: ex_merge.sv
`timescale 1ns/1ns

module ex_merge
	import ex_pkg::*;
(
	input  ex1_t ex1,
	output res_t res
);

	dword_t prod;
	xlen_t  mul_word;

	assign prod = ex1.part0 + ex1.part1; // wide final adder

	always_comb begin
		case (ex1.mul_type)
			MUL_MUL: begin
				mul_word = prod[XLEN-1:0];
			end
			MUL_MULH,
			MUL_MULHSU,
			MUL_MULHU: begin
				mul_word = prod[2*XLEN-1:XLEN];
			end
			default: begin
				mul_word = '0;
			end
		endcase
	end

	// alu and multiplier never both produce a value, so or-ing is a merge
	assign res = '{
		result:       ex1.alu_res | mul_word,
		branch_taken: ex1.branch_taken,
		target:       ex1.target
	};

	// an empty stage still holds unwritten data at startup
	a_alu_idle_on_mul: assert final (
		$isunknown(ex1.mul_type) || (ex1.mul_type == MUL_NONE) || (ex1.alu_res == '0)
	) else $error("alu result %h alongside multiply kind %0d", ex1.alu_res, ex1.mul_type);

endmodule

// File: ex_unit.sv
`timescale 1ns/1ns

module ex_unit
	import ex_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      in_valid,
	output logic      in_ready,
	input  op_type_t  op_type,
	input  mul_type_e mul_type,
	input  xlen_t     op0,
	input  xlen_t     op1,
	input  logic      is_branch,
	input  logic      is_jalr,
	input  xlen_t     pc,
	input  xlen_t     imm,
	input  xlen_t     rs1_data,

	output logic      out_valid,
	input  logic      out_ready,
	output xlen_t     result,
	output logic      branch_taken,
	output xlen_t     branch_target
);

	xlen_t  alu_res;
	logic   br_taken;
	xlen_t  br_target;
	dword_t part0;
	dword_t part1;
	ex1_t   ex1_d;
	ex1_t   ex1_q;
	logic   ex1_valid;
	logic   ex2_ready;
	res_t   res_d;
	res_t   res_q;

	// ==============================
	// ex1: alu and partial products
	// ==============================
	int_alu u_alu (
		.op_type       (op_type),
		.op0           (op0),
		.op1           (op1),
		.pc            (pc),
		.imm           (imm),
		.rs1_data      (rs1_data),
		.is_branch     (is_branch),
		.is_jalr       (is_jalr),
		.alu_res       (alu_res),
		.branch_taken  (br_taken),
		.branch_target (br_target)
	);

	mul_partial u_mul (
		.mul_type (mul_type),
		.op0      (op0),
		.op1      (op1),
		.part0    (part0),
		.part1    (part1)
	);

	assign ex1_d = '{
		alu_res:      alu_res,
		part0:        part0,
		part1:        part1,
		mul_type:     mul_type,
		branch_taken: br_taken,
		target:       br_target
	};

	pipe_reg #(.payload_t(ex1_t)) u_ex1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.out_ready (ex2_ready),
		.in_data   (ex1_d),
		.in_ready  (in_ready),
		.out_valid (ex1_valid),
		.out_data  (ex1_q)
	);

	// ==============================
	// ex2: product sum and merge
	// ==============================
	ex_merge u_merge (
		.ex1 (ex1_q),
		.res (res_d)
	);

	pipe_reg #(.payload_t(res_t)) u_ex2 (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (ex1_valid),
		.out_ready (out_ready),
		.in_data   (res_d),
		.in_ready  (ex2_ready),
		.out_valid (out_valid),
		.out_data  (res_q)
	);

	assign result        = res_q.result;
	assign branch_taken  = res_q.branch_taken;
	assign branch_target = res_q.target;

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: tb_ex_unit.sv
`timescale 1ns/1ns

module tb_ex_unit
	import ex_pkg::*;
();

	localparam int N_TESTS = 400;
	localparam int N_LAT   = 20; // first items run with out_ready held high

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	logic      in_ready;
	op_type_t  op_type;
	mul_type_e mul_type;
	xlen_t     op0;
	xlen_t     op1;
	logic      is_branch;
	logic      is_jalr;
	xlen_t     pc;
	xlen_t     imm;
	xlen_t     rs1_data;
	logic      out_valid;
	logic      out_ready;
	xlen_t     result;
	logic      branch_taken;
	xlen_t     branch_target;

	xlen_t     rng_state = 32'h877dffea;
	logic      random_ready;
	res_t      exp_q[$];
	int        acc_q[$];
	int        cycle;
	int        done_cnt;

	tb_clk_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	ex_unit u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.op_type       (op_type),
		.mul_type      (mul_type),
		.op0           (op0),
		.op1           (op1),
		.is_branch     (is_branch),
		.is_jalr       (is_jalr),
		.pc            (pc),
		.imm           (imm),
		.rs1_data      (rs1_data),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.result        (result),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	// ==============================
	// helpers
	// ==============================
	function automatic xlen_t next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// corner values show up often
	function automatic xlen_t pick_operand();
		xlen_t r;
		r = next_rand();
		case (r[2:0])
			3'd0: return '0;
			3'd1: return 32'h8000_0000;
			3'd2: return 32'hffff_ffff;
			3'd3: return 32'h7fff_ffff;
			3'd4: return 32'd31; // largest shift amount
			default: return next_rand();
		endcase
	endfunction

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		stop_run();
	endtask

	task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_target(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	// ==============================
	// reference model
	// ==============================
	function automatic res_t model(input op_type_t op, input mul_type_e mt, input xlen_t a,
		input xlen_t b, input logic br, input logic jr, input xlen_t pc_v,
		input xlen_t imm_v, input xlen_t rs1);
		res_t   r;
		dword_t pa;
		dword_t pb;
		dword_t prod;
		logic   cmp;
		int     idx;
		r   = '0;
		cmp = 1'b0;
		idx = -1;
		for (int i = 0; i < N_OPS; i++) begin
			if (op[i]) idx = i;
		end
		case (idx)
			OP_ADD: r.result = a + b;
			OP_SUB: r.result = a - b;
			OP_AND: r.result = a & b;
			OP_OR:  r.result = a | b;
			OP_XOR: r.result = a ^ b;
			OP_SLL: r.result = a << b[SHAMT_W-1:0];
			OP_SRL: r.result = a >> b[SHAMT_W-1:0];
			OP_SRA: r.result = $signed(a) >>> b[SHAMT_W-1:0];
			OP_LUI: r.result = b;
			OP_LT:  cmp = $signed(a) < $signed(b);
			OP_LTU: cmp = a < b;
			OP_EQ:  cmp = a == b;
			OP_NE:  cmp = a != b;
			OP_GE:  cmp = $signed(a) >= $signed(b);
			OP_GEU: cmp = a >= b;
			default: ;
		endcase
		if (idx >= OP_LT) r.result = xlen_t'(cmp);
		// 64 bit product of the extended operands is exact mod 2^64
		pa   = (mt == MUL_MULH || mt == MUL_MULHSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
		pb   = (mt == MUL_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
		prod = pa * pb;
		if (mt == MUL_MUL) r.result = prod[XLEN-1:0];
		if (mt == MUL_MULH || mt == MUL_MULHSU || mt == MUL_MULHU) r.result = prod[2*XLEN-1:XLEN];
		r.branch_taken = jr | (br & cmp);
		if (br) r.target = pc_v + imm_v;
		else if (jr) r.target = (rs1 + imm_v) & 32'hffff_fffe;
		return r;
	endfunction

	// ==============================
	// scoreboard
	// ==============================
	always @(posedge clk) begin : monitor
		res_t e;
		int   lat;
		if (rst_n) begin
			if (!in_ready && (exp_q.size() != 2 || out_ready))
				report_failure("in_ready was low while the pipeline was not full");
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) report_failure("a result came out with no input pending");
				e   = exp_q.pop_front();
				lat = cycle - acc_q.pop_front();
				if (lat < 2 || (done_cnt < N_LAT && lat != 2))
					report_failure($sformatf("result arrived %0d cycles after its input", lat));
				check_word("result", result, e.result);
				check_flag("branch_taken", branch_taken, e.branch_taken);
				check_target("branch_target", branch_target, e.target);
				done_cnt++;
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(model(op_type, mul_type, op0, op1, is_branch, is_jalr, pc, imm,
					rs1_data));
				acc_q.push_back(cycle);
			end
		end
		cycle++;
	end

	// ==============================
	// stimulus
	// ==============================
	task automatic step_cycle();
		@(posedge clk);
		if (random_ready) out_ready <= (next_rand() % 4) != 0;
	endtask

	task automatic drive_item();
		xlen_t     kind;
		xlen_t     a;
		xlen_t     b;
		xlen_t     pc_v;
		op_type_t  op_v;
		mul_type_e mt;
		logic      br;
		logic      jr;
		kind = next_rand() % 10;
		pc_v = next_rand() & 32'hffff_fffc;
		a    = pick_operand();
		b    = pick_operand();
		op_v = op_type_t'(1) << (next_rand() % N_OPS);
		mt   = MUL_NONE;
		br   = 1'b0;
		jr   = 1'b0;
		if (kind == 6 || kind == 7) begin
			op_v = '0;
			mt   = mul_type_e'(3'(next_rand() % 4 + 1));
		end else if (kind == 8) begin
			op_v = op_type_t'(1) << (OP_LT + next_rand() % 6); // compare opcodes only
			br   = 1'b1;
		end else if (kind == 9) begin
			op_v = op_type_t'(1) << OP_ADD;
			jr   = 1'b1;
			a    = pc_v;
			b    = 32'd4; // link value
		end
		in_valid  <= 1'b1;
		op_type   <= op_v;
		mul_type  <= mt;
		op0       <= a;
		op1       <= b;
		is_branch <= br;
		is_jalr   <= jr;
		pc        <= pc_v;
		imm       <= next_rand();
		rs1_data  <= next_rand();
		do step_cycle(); while (!in_ready);
	endtask

	initial begin
		in_valid     = 1'b0;
		op_type      = '0;
		mul_type     = MUL_NONE;
		op0          = '0;
		op1          = '0;
		is_branch    = 1'b0;
		is_jalr      = 1'b0;
		pc           = '0;
		imm          = '0;
		rs1_data     = '0;
		out_ready    = 1'b0; // in_ready must come from empty stages alone
		random_ready = 1'b0;
		cycle        = 0;
		done_cnt     = 0;

		wait (rst_n === 1'b1);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);
		@(posedge clk);
		out_ready <= 1'b1;

		// back to back with a free output, fixed latency
		repeat (N_LAT) drive_item();
		in_valid <= 1'b0;
		repeat (3) step_cycle();

		random_ready = 1'b1;
		repeat (N_TESTS - N_LAT) begin
			drive_item();
			if (next_rand() % 4 == 0) begin
				in_valid <= 1'b0;
				step_cycle();
			end
		end

		// drain
		random_ready = 1'b0;
		in_valid  <= 1'b0;
		out_ready <= 1'b1;
		while (done_cnt < N_TESTS) @(posedge clk);
		repeat (4) @(posedge clk);
		if (exp_q.size() == 0 && done_cnt == N_TESTS) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			report_failure("results were left unmatched at the end of the run");
		end
	end

	// watchdog
	initial begin
		repeat (N_TESTS * 20 + 4) @(posedge clk);
		report_failure("results stopped arriving before all inputs were answered");
	end

endmodule

// File: ex_unit.f
ex_pkg.sv
int_alu.sv
mul_partial.sv
pipe_reg.sv
ex_merge.sv
ex_unit.sv
tb_clk_gen.sv
tb_ex_unit.sv

// File: Bender.yml
package:
  name: ex_unit

sources:
  - files:
      - ex_pkg.sv
      - int_alu.sv
      - mul_partial.sv
      - pipe_reg.sv
      - ex_merge.sv
      - ex_unit.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_ex_unit.sv
